//--- include/wb_settings.svh
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// architectural widths
`define WB_DATA_W 32
`define WB_MM_W   64
`define WB_SEL_W  3
`define WB_CS_W   16

// state of EIP and CS out of reset
`define WB_RESET_EIP 32'h0000_fff0
`define WB_RESET_CS  16'hf000

`endif

//--- source/wb_pkg.sv
`default_nettype none

package wb_pkg;

   // micro-op opcodes seen by writeback
   typedef enum logic [3:0] {
      op_alu         = 4'h0,
      op_cmovc       = 4'h1,
      // conditional near branches
      op_jne         = 4'h2,
      op_jnbe        = 4'h3,
      op_jmp_far     = 4'h4,
      op_push_flags  = 4'h5,
      op_pop_flags   = 4'h6,
      // 32-bit and 64-bit data cache writes
      op_store       = 4'h7,
      op_store_mm    = 4'h8,
      // two-uop compare string sequence
      op_cmps_first  = 4'h9,
      op_cmps_second = 4'ha,
      op_halt        = 4'hb,
      op_nop         = 4'hc
   } wb_op_e;

   // data cache write master
   typedef enum logic [1:0] {
      idle      = 2'd0,
      addr_data = 2'd1,
      resp      = 2'd2
   } store_state_e;

   // positions in the EFLAGS word
   localparam int flag_cf = 0;
   localparam int flag_zf = 6;

endpackage

`default_nettype wire

//--- source/wb_uop_if.sv
`default_nettype none
`include "wb_settings.svh"

// accepted micro-op inside the writeback stage
interface wb_uop_if;
   logic                   fire;
   wb_pkg::wb_op_e         op;
   logic [`WB_SEL_W-1:0]   dr1;
   logic [`WB_SEL_W-1:0]   dr2;
   logic [`WB_SEL_W-1:0]   dr3;
   logic [`WB_DATA_W-1:0]  result_a;
   logic [`WB_DATA_W-1:0]  result_b;
   logic [`WB_DATA_W-1:0]  result_c;
   logic [`WB_MM_W-1:0]    result_mm;
   logic [`WB_DATA_W-1:0]  alu_flags;
   logic [`WB_DATA_W-1:0]  flags_mask;
   logic [`WB_DATA_W-1:0]  neip;
   logic [`WB_DATA_W-1:0]  neip_not_taken;
   logic [`WB_CS_W-1:0]    ncs;
   logic [`WB_DATA_W-1:0]  address;
   logic                   ld_gpr1;
   logic                   ld_gpr2;
   logic                   ld_seg;
   logic                   ld_mm;
   logic                   repne;

   modport src (output fire, op, dr1, dr2, dr3, result_a, result_b, result_c, result_mm,
      alu_flags, flags_mask, neip, neip_not_taken, ncs, address, ld_gpr1, ld_gpr2, ld_seg,
      ld_mm, repne);
   modport sink (input fire, op, dr1, dr2, dr3, result_a, result_b, result_c, result_mm,
      alu_flags, flags_mask, neip, neip_not_taken, ncs, address, ld_gpr1, ld_gpr2, ld_seg,
      ld_mm, repne);
endinterface

// store request from commit to the write master
interface wb_store_if;
   logic                   req;
   logic [`WB_DATA_W-1:0]  addr;
   logic [`WB_MM_W-1:0]    data;
   logic [`WB_MM_W/8-1:0]  strb;
   logic                   busy;

   modport master (output req, addr, data, strb, input busy);
   modport slave (input req, addr, data, strb, output busy);
endinterface

`default_nettype wire

//--- source/flags_wb.sv
`default_nettype none
`include "wb_settings.svh"

module flags_wb (
   input  logic                  CLK,
   input  logic                  rst,
   wb_uop_if.sink                uop,
   output logic [`WB_DATA_W-1:0] next_flags,
   output logic [`WB_DATA_W-1:0] cur_flags
);

   logic [`WB_DATA_W-1:0] merged;

   // alu flags only where the uop says they are affected
   assign merged = (uop.alu_flags & uop.flags_mask) | (cur_flags & ~uop.flags_mask);

   always_comb begin
      if (uop.op == wb_pkg::op_pop_flags) begin
         next_flags = uop.result_a;
      end else begin
         next_flags = merged;
      end
   end

   always_ff @(posedge CLK) begin
      if (rst) begin
         cur_flags <= '0;
      end else if (uop.fire) begin
         cur_flags <= next_flags;
      end
   end

   // a nop carries no flag mask, so the register holds
   nop_keeps_flags: assert property (
      @(posedge CLK) disable iff (rst)
      uop.fire && uop.op == wb_pkg::op_nop |=> $stable(cur_flags)
   ) else $error("flags changed on a nop micro-op");

endmodule

`default_nettype wire

//--- source/operand_select_wb.sv
`default_nettype none
`include "wb_settings.svh"

module operand_select_wb (
   input  logic                  CLK,
   input  logic                  rst,
   wb_uop_if.sink                uop,
   input  logic [`WB_DATA_W-1:0] next_flags,
   input  logic                  taken,
   output logic [`WB_DATA_W-1:0] sel_data1,
   output logic [`WB_DATA_W-1:0] sel_eip,
   output logic [`WB_CS_W-1:0]   sel_cs,
   output logic [`WB_DATA_W-1:0] count
);

   logic is_cmps;

   // pushf writes the flags as they stand after this uop
   always_comb begin
      if (uop.op == wb_pkg::op_push_flags) begin
         sel_data1 = next_flags;
      end else begin
         sel_data1 = uop.result_a;
      end
   end

   // fall-through address when a conditional branch is not taken
   always_comb begin
      if (taken) begin
         sel_eip = uop.neip;
      end else begin
         sel_eip = uop.neip_not_taken;
      end
   end

   assign sel_cs = uop.ncs;

   assign is_cmps = (uop.op == wb_pkg::op_cmps_first) || (uop.op == wb_pkg::op_cmps_second);

   // string count, forwarded to the earlier stages
   always_ff @(posedge CLK) begin
      if (rst) begin
         count <= '0;
      end else if (uop.fire && is_cmps) begin
         count <= uop.result_c;
      end
   end

endmodule

`default_nettype wire

//--- source/commit_wb.sv
`default_nettype none
`include "wb_settings.svh"

module commit_wb (
   input  logic                  CLK,
   input  logic                  rst,
   wb_uop_if.sink                uop,
   input  logic [`WB_DATA_W-1:0] next_flags,
   input  logic [`WB_DATA_W-1:0] sel_data1,
   input  logic [`WB_DATA_W-1:0] sel_eip,
   input  logic [`WB_CS_W-1:0]   sel_cs,
   output logic                  taken,
   wb_store_if.master            store,
   output logic [`WB_SEL_W-1:0]  dr1,
   output logic [`WB_SEL_W-1:0]  dr2,
   output logic [`WB_SEL_W-1:0]  dr3,
   output logic [`WB_DATA_W-1:0] data1,
   output logic [`WB_DATA_W-1:0] data2,
   output logic [`WB_DATA_W-1:0] data3,
   output logic [`WB_MM_W-1:0]   mm_data,
   output logic                  ld_gpr1,
   output logic                  ld_gpr2,
   output logic                  ld_gpr3,
   output logic                  ld_mm,
   output logic                  ld_seg,
   output logic                  ld_eip,
   output logic [`WB_DATA_W-1:0] eip,
   output logic                  ld_cs,
   output logic [`WB_CS_W-1:0]   cs,
   output logic                  ld_flags,
   output logic                  halt,
   output logic                  repne_terminate
);

   logic cf;
   logic zf;
   logic gpr2_ok;
   logic eip_op;
   logic cs_op;
   logic flags_op;
   logic repne_hit;
   logic is_mm_store;

   assign cf = next_flags[wb_pkg::flag_cf];
   assign zf = next_flags[wb_pkg::flag_zf];

   always_comb begin
      case (uop.op)
         wb_pkg::op_jne:  taken = !zf;
         wb_pkg::op_jnbe: taken = !cf && !zf;
         default:         taken = 1'b1;
      endcase
   end

   // cmovc moves only with carry set
   assign gpr2_ok = uop.ld_gpr2 && (uop.op != wb_pkg::op_cmovc || cf);

   assign eip_op = uop.op inside {wb_pkg::op_jne, wb_pkg::op_jnbe, wb_pkg::op_jmp_far,
                                  wb_pkg::op_halt};
   assign cs_op = (uop.op == wb_pkg::op_jmp_far);
   assign flags_op = (uop.op == wb_pkg::op_pop_flags) || (|uop.flags_mask);

   // repne cmps stops on a match or when ecx runs out
   assign repne_hit = (uop.op == wb_pkg::op_cmps_second) && uop.repne &&
                      (zf || uop.result_c == '0);

   assign is_mm_store = (uop.op == wb_pkg::op_store_mm);
   assign store.req = uop.fire && (uop.op == wb_pkg::op_store || is_mm_store);
   assign store.addr = uop.address;
   assign store.data = is_mm_store ? uop.result_mm
                                   : {{(`WB_MM_W - `WB_DATA_W){1'b0}}, sel_data1};
   assign store.strb = is_mm_store ? 8'hff : 8'h0f;

   always_ff @(posedge CLK) begin
      if (rst) begin
         ld_gpr1         <= 1'b0;
         ld_gpr2         <= 1'b0;
         ld_gpr3         <= 1'b0;
         ld_mm           <= 1'b0;
         ld_seg          <= 1'b0;
         ld_eip          <= 1'b0;
         ld_cs           <= 1'b0;
         ld_flags        <= 1'b0;
         halt            <= 1'b0;
         repne_terminate <= 1'b0;
         eip             <= `WB_RESET_EIP;
         cs              <= `WB_RESET_CS;
      end else begin
         ld_gpr1         <= uop.fire && uop.ld_gpr1;
         ld_gpr2         <= uop.fire && gpr2_ok;
         ld_gpr3         <= uop.fire && uop.repne && uop.op == wb_pkg::op_cmps_second;
         ld_mm           <= uop.fire && uop.ld_mm;
         ld_seg          <= uop.fire && uop.ld_seg;
         ld_eip          <= uop.fire && eip_op;
         ld_cs           <= uop.fire && cs_op;
         ld_flags        <= uop.fire && flags_op;
         repne_terminate <= uop.fire && repne_hit;
         // sticky until reset
         if (uop.fire && uop.op == wb_pkg::op_halt) begin
            halt <= 1'b1;
         end
         if (uop.fire && eip_op) begin
            eip <= sel_eip;
         end
         if (uop.fire && cs_op) begin
            cs <= sel_cs;
         end
      end
   end

   always_ff @(posedge CLK) begin
      dr1     <= uop.dr1;
      dr2     <= uop.dr2;
      dr3     <= uop.dr3;
      data1   <= sel_data1;
      data2   <= uop.result_b;
      data3   <= uop.result_c;
      mm_data <= uop.result_mm;
   end

   no_req_while_busy: assert property (
      @(posedge CLK) disable iff (rst) store.req |-> !store.busy
   ) else $error("store request issued while the write master is busy");

   // far jump commits cs and eip together
   cs_with_eip: assert property (
      @(posedge CLK) disable iff (rst) ld_cs |-> ld_eip
   ) else $error("ld_cs without ld_eip");

endmodule

`default_nettype wire

//--- source/dcache_store_axil.sv
`default_nettype none
`include "wb_settings.svh"

module dcache_store_axil (
   input  logic                    CLK,
   input  logic                    rst,
   wb_store_if.slave               store,
   output logic [`WB_DATA_W-1:0]   awaddr,
   output logic                    awvalid,
   input  logic                    awready,
   output logic [`WB_MM_W-1:0]     wdata,
   output logic [`WB_MM_W/8-1:0]   wstrb,
   output logic                    wvalid,
   input  logic                    wready,
   input  logic [1:0]              bresp,
   input  logic                    bvalid,
   output logic                    bready,
   output logic                    store_error
);

   wb_pkg::store_state_e state;
   logic aw_done;
   logic w_done;

   // each channel may complete on its own cycle
   assign aw_done = !awvalid || awready;
   assign w_done = !wvalid || wready;

   assign bready = (state == wb_pkg::resp);
   assign store.busy = (state != wb_pkg::idle);

   always_ff @(posedge CLK) begin
      if (rst) begin
         state       <= wb_pkg::idle;
         awvalid     <= 1'b0;
         wvalid      <= 1'b0;
         store_error <= 1'b0;
      end else begin
         case (state)
            wb_pkg::idle: begin
               if (store.req) begin
                  awvalid <= 1'b1;
                  wvalid  <= 1'b1;
                  state   <= wb_pkg::addr_data;
               end
            end
            wb_pkg::addr_data: begin
               if (awready) begin
                  awvalid <= 1'b0;
               end
               if (wready) begin
                  wvalid <= 1'b0;
               end
               if (aw_done && w_done) begin
                  state <= wb_pkg::resp;
               end
            end
            wb_pkg::resp: begin
               if (bvalid) begin
                  state <= wb_pkg::idle;
                  // anything but OKAY
                  if (bresp != 2'b00) begin
                     store_error <= 1'b1;
                  end
               end
            end
            default: state <= wb_pkg::idle;
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (store.req && state == wb_pkg::idle) begin
         awaddr <= store.addr;
         wdata  <= store.data;
         wstrb  <= store.strb;
      end
   end

   aw_hold: assert property (
      @(posedge CLK) disable iff (rst)
      awvalid && !awready |=> awvalid && $stable(awaddr)
   ) else $error("awaddr changed before awready");

endmodule

`default_nettype wire

//--- source/writeback.sv
`default_nettype none
`include "wb_settings.svh"

module writeback (
   input  logic                    CLK,
   input  logic                    rst,
   input  logic                    in_valid,
   output logic                    in_ready,
   input  wb_pkg::wb_op_e          uop_op,
   input  logic [`WB_SEL_W-1:0]    uop_dr1,
   input  logic [`WB_SEL_W-1:0]    uop_dr2,
   input  logic [`WB_SEL_W-1:0]    uop_dr3,
   input  logic [`WB_DATA_W-1:0]   uop_result_a,
   input  logic [`WB_DATA_W-1:0]   uop_result_b,
   input  logic [`WB_DATA_W-1:0]   uop_result_c,
   input  logic [`WB_MM_W-1:0]     uop_result_mm,
   input  logic [`WB_DATA_W-1:0]   uop_alu_flags,
   input  logic [`WB_DATA_W-1:0]   uop_flags_mask,
   input  logic [`WB_DATA_W-1:0]   uop_neip,
   input  logic [`WB_DATA_W-1:0]   uop_neip_not_taken,
   input  logic [`WB_CS_W-1:0]     uop_ncs,
   input  logic [`WB_DATA_W-1:0]   uop_address,
   input  logic                    uop_ld_gpr1,
   input  logic                    uop_ld_gpr2,
   input  logic                    uop_ld_seg,
   input  logic                    uop_ld_mm,
   input  logic                    uop_repne,
   output logic [`WB_SEL_W-1:0]    dr1,
   output logic [`WB_SEL_W-1:0]    dr2,
   output logic [`WB_SEL_W-1:0]    dr3,
   output logic [`WB_DATA_W-1:0]   data1,
   output logic [`WB_DATA_W-1:0]   data2,
   output logic [`WB_DATA_W-1:0]   data3,
   output logic [`WB_MM_W-1:0]     mm_data,
   output logic                    ld_gpr1,
   output logic                    ld_gpr2,
   output logic                    ld_gpr3,
   output logic                    ld_mm,
   output logic                    ld_seg,
   output logic                    ld_eip,
   output logic [`WB_DATA_W-1:0]   eip,
   output logic                    ld_cs,
   output logic [`WB_CS_W-1:0]     cs,
   output logic                    ld_flags,
   output logic                    halt,
   output logic                    repne_terminate,
   output logic [`WB_DATA_W-1:0]   flags_fwd,
   output logic [`WB_DATA_W-1:0]   count_fwd,
   output logic [`WB_DATA_W-1:0]   awaddr,
   output logic                    awvalid,
   input  logic                    awready,
   output logic [`WB_MM_W-1:0]     wdata,
   output logic [`WB_MM_W/8-1:0]   wstrb,
   output logic                    wvalid,
   input  logic                    wready,
   input  logic [1:0]              bresp,
   input  logic                    bvalid,
   output logic                    bready,
   output logic                    store_error
);

   wb_uop_if   uop ();
   wb_store_if store ();

   logic [`WB_DATA_W-1:0] next_flags;
   logic [`WB_DATA_W-1:0] sel_data1;
   logic [`WB_DATA_W-1:0] sel_eip;
   logic [`WB_CS_W-1:0]   sel_cs;
   logic                  taken;

   // stall while a store is in flight, and for good after halt
   assign in_ready = !store.busy && !halt;

   assign uop.fire           = in_valid && in_ready;
   assign uop.op             = uop_op;
   assign uop.dr1            = uop_dr1;
   assign uop.dr2            = uop_dr2;
   assign uop.dr3            = uop_dr3;
   assign uop.result_a       = uop_result_a;
   assign uop.result_b       = uop_result_b;
   assign uop.result_c       = uop_result_c;
   assign uop.result_mm      = uop_result_mm;
   assign uop.alu_flags      = uop_alu_flags;
   assign uop.flags_mask     = uop_flags_mask;
   assign uop.neip           = uop_neip;
   assign uop.neip_not_taken = uop_neip_not_taken;
   assign uop.ncs            = uop_ncs;
   assign uop.address        = uop_address;
   assign uop.ld_gpr1        = uop_ld_gpr1;
   assign uop.ld_gpr2        = uop_ld_gpr2;
   assign uop.ld_seg         = uop_ld_seg;
   assign uop.ld_mm          = uop_ld_mm;
   assign uop.repne          = uop_repne;

   flags_wb flags_inst (
      .CLK(CLK), .rst(rst), .uop(uop), .next_flags(next_flags), .cur_flags(flags_fwd)
   );

   operand_select_wb operand_select_inst (
      .CLK(CLK), .rst(rst), .uop(uop), .next_flags(next_flags), .taken(taken),
      .sel_data1(sel_data1), .sel_eip(sel_eip), .sel_cs(sel_cs), .count(count_fwd)
   );

   commit_wb commit_inst (
      .CLK(CLK), .rst(rst), .uop(uop), .next_flags(next_flags),
      .sel_data1(sel_data1), .sel_eip(sel_eip), .sel_cs(sel_cs), .taken(taken),
      .store(store), .dr1(dr1), .dr2(dr2), .dr3(dr3),
      .data1(data1), .data2(data2), .data3(data3), .mm_data(mm_data),
      .ld_gpr1(ld_gpr1), .ld_gpr2(ld_gpr2), .ld_gpr3(ld_gpr3), .ld_mm(ld_mm),
      .ld_seg(ld_seg), .ld_eip(ld_eip), .eip(eip), .ld_cs(ld_cs), .cs(cs),
      .ld_flags(ld_flags), .halt(halt), .repne_terminate(repne_terminate)
   );

   dcache_store_axil store_inst (
      .CLK(CLK), .rst(rst), .store(store),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready), .store_error(store_error)
   );

endmodule

`default_nettype wire

//--- test/writeback_tb.sv
`default_nettype none
`include "wb_settings.svh"

module writeback_tb;

   localparam int clk_period = 4;
   localparam int num_uops = 400;
   localparam int worst_store_cycles = 40;

   logic CLK;
   logic rst;
   logic in_valid;
   logic in_ready;
   wb_pkg::wb_op_e uop_op;
   logic [`WB_SEL_W-1:0] uop_dr1, uop_dr2, uop_dr3;
   logic [`WB_DATA_W-1:0] uop_result_a, uop_result_b, uop_result_c;
   logic [`WB_MM_W-1:0] uop_result_mm;
   logic [`WB_DATA_W-1:0] uop_alu_flags, uop_flags_mask;
   logic [`WB_DATA_W-1:0] uop_neip, uop_neip_not_taken, uop_address;
   logic [`WB_CS_W-1:0] uop_ncs;
   logic uop_ld_gpr1, uop_ld_gpr2, uop_ld_seg, uop_ld_mm, uop_repne;
   logic [`WB_SEL_W-1:0] dr1, dr2, dr3;
   logic [`WB_DATA_W-1:0] data1, data2, data3;
   logic [`WB_MM_W-1:0] mm_data;
   logic ld_gpr1, ld_gpr2, ld_gpr3, ld_mm, ld_seg, ld_eip, ld_cs, ld_flags;
   logic [`WB_DATA_W-1:0] eip;
   logic [`WB_CS_W-1:0] cs;
   logic halt, repne_terminate, store_error;
   logic [`WB_DATA_W-1:0] flags_fwd, count_fwd, awaddr;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic [`WB_MM_W-1:0] wdata;
   logic [`WB_MM_W/8-1:0] wstrb;
   logic [1:0] bresp;

   // reference state and expected commits
   logic [31:0] lfsr = 32'd66;
   logic chk;
   logic [`WB_DATA_W-1:0] m_flags, m_eip, m_count, e_data1, e_data2, e_data3;
   logic [`WB_SEL_W-1:0] e_dr1, e_dr2, e_dr3;
   logic [`WB_CS_W-1:0] m_cs;
   logic [`WB_MM_W-1:0] e_mm_data, e_st_data;
   logic [`WB_DATA_W-1:0] e_st_addr;
   logic [7:0] e_st_strb;
   logic [4:0] e_loads;
   logic [3:0] e_ctl;
   logic m_halt, pending, aw_seen, w_seen;
   int issued = 0;
   int stores = 0;
   int value_errors = 0;
   int protocol_errors = 0;

   writeback writeback_inst (.*);

   initial begin
      CLK = 1'b0;
      forever #(clk_period / 2) CLK = ~CLK;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // one lfsr step per bit taken
   task automatic draw(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic value_error(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      value_errors++;
      $display("Error %0t %s expected %h actual %h", $time, name, exp, act);
   endtask

   task automatic protocol_error(input string what);
      protocol_errors++;
      $display("at %0t: %s", $time, what);
   endtask

   task automatic next_uop(input logic last);
      logic [63:0] r;
      wb_pkg::wb_op_e op;
      draw(4, r);
      if (last) begin
         op = wb_pkg::op_halt;
      end else if (r[3:0] == 4'hb || r[3:0] > 4'hc) begin
         op = wb_pkg::op_alu;
      end else begin
         op = wb_pkg::wb_op_e'(r[3:0]);
      end
      uop_op <= op;
      draw(9, r);
      uop_dr1 <= r[2:0];
      uop_dr2 <= r[5:3];
      uop_dr3 <= r[8:6];
      draw(64, r);
      uop_result_a <= r[31:0];
      uop_result_b <= r[63:32];
      draw(34, r);
      // a zero count now and then
      uop_result_c <= (r[1:0] == 2'b00) ? '0 : r[33:2];
      draw(64, r);
      uop_result_mm <= r;
      draw(32, r);
      uop_alu_flags <= r[31:0];
      draw(33, r);
      uop_flags_mask <= (r[32] || op == wb_pkg::op_nop) ? '0 : r[31:0];
      draw(64, r);
      uop_neip <= r[31:0];
      uop_neip_not_taken <= r[63:32];
      draw(53, r);
      uop_ncs <= r[15:0];
      uop_address <= r[47:16];
      uop_ld_gpr1 <= r[48];
      uop_ld_gpr2 <= r[49];
      uop_ld_seg <= r[50];
      uop_ld_mm <= r[51];
      uop_repne <= r[52];
   endtask

   // uop source and axi slave share one process for a fixed lfsr order
   always @(posedge CLK) begin : drive_stimulus
      logic [63:0] r;
      if (rst) begin
         in_valid <= 1'b0;
         awready <= 1'b0;
         wready <= 1'b0;
         bvalid <= 1'b0;
      end else begin
         draw(3, r);
         awready <= r[0];
         wready <= r[1];
         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end else if (bready) begin
            bvalid <= r[2];
         end
         if (!in_valid || in_ready) begin
            if (issued < num_uops) begin
               next_uop(issued == num_uops - 1);
               in_valid <= 1'b1;
               issued <= issued + 1;
            end else begin
               in_valid <= 1'b0;
            end
         end
      end
   end

   always @(posedge CLK) begin : reference_model
      logic fire;
      logic [31:0] nf;
      logic cf;
      logic zf;
      logic tk;
      logic eip_op;
      fire = in_valid && in_ready;
      if (uop_op == wb_pkg::op_pop_flags) begin
         nf = uop_result_a;
      end else begin
         nf = (uop_alu_flags & uop_flags_mask) | (m_flags & ~uop_flags_mask);
      end
      cf = nf[wb_pkg::flag_cf];
      zf = nf[wb_pkg::flag_zf];
      tk = (uop_op == wb_pkg::op_jne) ? !zf : (uop_op == wb_pkg::op_jnbe) ? !cf && !zf : 1'b1;
      eip_op = uop_op inside {wb_pkg::op_jne, wb_pkg::op_jnbe, wb_pkg::op_jmp_far,
                              wb_pkg::op_halt};
      if (rst) begin
         chk <= 1'b0;
         m_flags <= '0;
         m_eip <= `WB_RESET_EIP;
         m_cs <= `WB_RESET_CS;
         m_count <= '0;
         m_halt <= 1'b0;
         e_loads <= '0;
         e_ctl <= '0;
         pending <= 1'b0;
         aw_seen <= 1'b0;
         w_seen <= 1'b0;
      end else begin
         chk <= fire;
         e_dr1 <= uop_dr1;
         e_dr2 <= uop_dr2;
         e_dr3 <= uop_dr3;
         e_data1 <= (uop_op == wb_pkg::op_push_flags) ? nf : uop_result_a;
         e_data2 <= uop_result_b;
         e_data3 <= uop_result_c;
         e_mm_data <= uop_result_mm;
         e_loads <= {5{fire}} & {uop_ld_gpr1, uop_ld_gpr2 && (uop_op != wb_pkg::op_cmovc || cf),
                     uop_op == wb_pkg::op_cmps_second && uop_repne, uop_ld_mm, uop_ld_seg};
         e_ctl <= {4{fire}} & {eip_op, uop_op == wb_pkg::op_jmp_far,
                  uop_op == wb_pkg::op_pop_flags || (|uop_flags_mask),
                  uop_op == wb_pkg::op_cmps_second && uop_repne && (zf || uop_result_c == '0)};
         if (fire) begin
            m_flags <= nf;
            if (eip_op) begin
               m_eip <= tk ? uop_neip : uop_neip_not_taken;
            end
            if (uop_op == wb_pkg::op_jmp_far) begin
               m_cs <= uop_ncs;
            end
            if (uop_op inside {wb_pkg::op_cmps_first, wb_pkg::op_cmps_second}) begin
               m_count <= uop_result_c;
            end
            if (uop_op == wb_pkg::op_halt) begin
               m_halt <= 1'b1;
            end
            if (uop_op inside {wb_pkg::op_store, wb_pkg::op_store_mm}) begin
               pending <= 1'b1;
               e_st_addr <= uop_address;
               e_st_data <= (uop_op == wb_pkg::op_store_mm) ? uop_result_mm
                                                            : {32'h0, uop_result_a};
               e_st_strb <= (uop_op == wb_pkg::op_store_mm) ? 8'hff : 8'h0f;
            end
         end
         if (awvalid && awready) begin
            aw_seen <= 1'b1;
         end
         if (wvalid && wready) begin
            w_seen <= 1'b1;
         end
         if (bvalid && bready) begin
            pending <= 1'b0;
            aw_seen <= 1'b0;
            w_seen <= 1'b0;
            stores <= stores + 1;
         end
      end
   end

   dr_check: assert property (@(posedge CLK) disable iff (rst)
      chk |-> {dr1, dr2, dr3} == {e_dr1, e_dr2, e_dr3})
      else value_error("{dr1,dr2,dr3}", $sampled({e_dr1, e_dr2, e_dr3}),
                       $sampled({dr1, dr2, dr3}));
   data1_check: assert property (@(posedge CLK) disable iff (rst) chk |-> data1 == e_data1)
      else value_error("data1", $sampled(e_data1), $sampled(data1));
   data2_check: assert property (@(posedge CLK) disable iff (rst) chk |-> data2 == e_data2)
      else value_error("data2", $sampled(e_data2), $sampled(data2));
   data3_check: assert property (@(posedge CLK) disable iff (rst) chk |-> data3 == e_data3)
      else value_error("data3", $sampled(e_data3), $sampled(data3));
   mm_check: assert property (@(posedge CLK) disable iff (rst) chk |-> mm_data == e_mm_data)
      else value_error("mm_data", $sampled(e_mm_data), $sampled(mm_data));
   loads_check: assert property (@(posedge CLK) disable iff (rst)
      {ld_gpr1, ld_gpr2, ld_gpr3, ld_mm, ld_seg} == e_loads)
      else value_error("{ld_gpr1,ld_gpr2,ld_gpr3,ld_mm,ld_seg}", $sampled(e_loads),
                       $sampled({ld_gpr1, ld_gpr2, ld_gpr3, ld_mm, ld_seg}));
   ctl_check: assert property (@(posedge CLK) disable iff (rst)
      {ld_eip, ld_cs, ld_flags, repne_terminate} == e_ctl)
      else value_error("{ld_eip,ld_cs,ld_flags,repne_terminate}", $sampled(e_ctl),
                       $sampled({ld_eip, ld_cs, ld_flags, repne_terminate}));
   flags_check: assert property (@(posedge CLK) disable iff (rst) flags_fwd == m_flags)
      else value_error("flags_fwd", $sampled(m_flags), $sampled(flags_fwd));
   eip_check: assert property (@(posedge CLK) disable iff (rst) eip == m_eip)
      else value_error("eip", $sampled(m_eip), $sampled(eip));
   cs_check: assert property (@(posedge CLK) disable iff (rst) cs == m_cs)
      else value_error("cs", $sampled(m_cs), $sampled(cs));
   count_check: assert property (@(posedge CLK) disable iff (rst) count_fwd == m_count)
      else value_error("count_fwd", $sampled(m_count), $sampled(count_fwd));
   halt_check: assert property (@(posedge CLK) disable iff (rst) halt == m_halt)
      else value_error("halt", $sampled(m_halt), $sampled(halt));
   // stalled while a store is open, and for good after halt
   ready_check: assert property (@(posedge CLK) disable iff (rst)
      in_ready == !(pending || m_halt))
      else value_error("in_ready", $sampled(!(pending || m_halt)), $sampled(in_ready));
   awaddr_check: assert property (@(posedge CLK) disable iff (rst)
      awvalid && awready |-> awaddr == e_st_addr)
      else value_error("awaddr", $sampled(e_st_addr), $sampled(awaddr));
   wdata_check: assert property (@(posedge CLK) disable iff (rst)
      wvalid && wready |-> wdata == e_st_data)
      else value_error("wdata", $sampled(e_st_data), $sampled(wdata));
   wstrb_check: assert property (@(posedge CLK) disable iff (rst)
      wvalid && wready |-> wstrb == e_st_strb)
      else value_error("wstrb", $sampled(e_st_strb), $sampled(wstrb));
   aw_once: assert property (@(posedge CLK) disable iff (rst)
      awvalid && awready |-> pending && !aw_seen)
      else protocol_error("write address accepted with no store open, or twice");
   w_once: assert property (@(posedge CLK) disable iff (rst)
      wvalid && wready |-> pending && !w_seen)
      else protocol_error("write data accepted with no store open, or twice");
   b_after_aw_w: assert property (@(posedge CLK) disable iff (rst)
      bvalid && bready |-> aw_seen && w_seen)
      else protocol_error("write response taken before address and data were both accepted");
   no_store_error: assert property (@(posedge CLK) disable iff (rst) !store_error)
      else value_error("store_error", 64'h0, $sampled(store_error));

   initial begin
      rst = 1'b1;
      in_valid = 1'b0;
      uop_op = wb_pkg::op_nop;
      {uop_dr1, uop_dr2, uop_dr3} = '0;
      {uop_result_a, uop_result_b, uop_result_c, uop_result_mm} = '0;
      {uop_alu_flags, uop_flags_mask, uop_neip, uop_neip_not_taken} = '0;
      {uop_ncs, uop_address} = '0;
      {uop_ld_gpr1, uop_ld_gpr2, uop_ld_seg, uop_ld_mm, uop_repne} = '0;
      {awready, wready, bvalid} = '0;
      bresp = 2'b00;
      repeat (4) @(posedge CLK);
      rst <= 1'b0;
      // last uop is the halt
      wait (issued == num_uops && halt);
      repeat (8) @(posedge CLK);
      $display("writeback: %0d micro-ops, %0d stores, %0d value errors, %0d protocol errors",
               issued, stores, value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(num_uops * worst_store_cycles * clk_period);
      $display("watchdog expired before the halt micro-op committed");
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
source/wb_pkg.sv
source/wb_uop_if.sv
source/flags_wb.sv
source/operand_select_wb.sv
source/commit_wb.sv
source/dcache_store_axil.sv
source/writeback.sv
test/writeback_tb.sv
